//--- common/decode_pkg.sv
package decode_pkg;

        typedef logic [31:0] inst_t;
        typedef logic [4:0]  reg_addr_t;

        localparam reg_addr_t LINK_REG = 5'd31;

        // Major opcodes
        localparam logic [5:0] OPC_SPECIAL = 6'b000000;
        localparam logic [5:0] OPC_COP0    = 6'b010000;
        localparam logic [5:0] OPC_ADDI    = 6'b001000;
        localparam logic [5:0] OPC_ADDIU   = 6'b001001;
        localparam logic [5:0] OPC_SLTI    = 6'b001010;
        localparam logic [5:0] OPC_SLTIU   = 6'b001011;
        localparam logic [5:0] OPC_ANDI    = 6'b001100;
        localparam logic [5:0] OPC_ORI     = 6'b001101;
        localparam logic [5:0] OPC_XORI    = 6'b001110;
        localparam logic [5:0] OPC_LUI     = 6'b001111;
        localparam logic [5:0] OPC_LB      = 6'b100000;
        localparam logic [5:0] OPC_LH      = 6'b100001;
        localparam logic [5:0] OPC_LW      = 6'b100011;
        localparam logic [5:0] OPC_LBU     = 6'b100100;
        localparam logic [5:0] OPC_LHU     = 6'b100101;
        localparam logic [5:0] OPC_SB      = 6'b101000;
        localparam logic [5:0] OPC_SH      = 6'b101001;
        localparam logic [5:0] OPC_SW      = 6'b101011;

        // SPECIAL functs
        localparam logic [5:0] FN_SLL     = 6'b000000;
        localparam logic [5:0] FN_SRL     = 6'b000010;
        localparam logic [5:0] FN_SRA     = 6'b000011;
        localparam logic [5:0] FN_SLLV    = 6'b000100;
        localparam logic [5:0] FN_SRLV    = 6'b000110;
        localparam logic [5:0] FN_SRAV    = 6'b000111;
        localparam logic [5:0] FN_SYSCALL = 6'b001100;
        localparam logic [5:0] FN_BREAK   = 6'b001101;
        localparam logic [5:0] FN_MFHI    = 6'b010000;
        localparam logic [5:0] FN_MTHI    = 6'b010001;
        localparam logic [5:0] FN_MFLO    = 6'b010010;
        localparam logic [5:0] FN_MTLO    = 6'b010011;
        localparam logic [5:0] FN_MULT    = 6'b011000;
        localparam logic [5:0] FN_MULTU   = 6'b011001;
        localparam logic [5:0] FN_DIV     = 6'b011010;
        localparam logic [5:0] FN_DIVU    = 6'b011011;
        localparam logic [5:0] FN_ADD     = 6'b100000;
        localparam logic [5:0] FN_ADDU    = 6'b100001;
        localparam logic [5:0] FN_SUB     = 6'b100010;
        localparam logic [5:0] FN_SUBU    = 6'b100011;
        localparam logic [5:0] FN_AND     = 6'b100100;
        localparam logic [5:0] FN_OR      = 6'b100101;
        localparam logic [5:0] FN_XOR     = 6'b100110;
        localparam logic [5:0] FN_NOR     = 6'b100111;
        localparam logic [5:0] FN_SLT     = 6'b101010;
        localparam logic [5:0] FN_SLTU    = 6'b101011;

        // Coprocessor 0
        localparam inst_t      ERET_WORD = 32'h4200_0018;
        localparam logic [4:0] COP0_MF   = 5'b00000;
        localparam logic [4:0] COP0_MT   = 5'b00100;
        localparam logic [5:0] FN_TLBP   = 6'b001000;
        localparam logic [5:0] FN_TLBR   = 6'b000001;
        localparam logic [5:0] FN_TLBWI  = 6'b000010;
        localparam logic [5:0] FN_TLBWR  = 6'b000110;

        typedef enum logic [5:0] {
                ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
                ALU_DIV, ALU_DIVU, ALU_MULT, ALU_MULTU, ALU_AND, ALU_OR,
                ALU_XOR, ALU_NOR, ALU_LUI, ALU_SLL, ALU_SRL, ALU_SRA,
                ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO, ALU_BREK, ALU_SYSC,
                ALU_ERET, ALU_MFC0, ALU_MTC0, ALU_TLBP, ALU_TLBR, ALU_TLBWI,
                ALU_TLBWR, ALU_OUTA
        } alu_op_e;

        typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_SFT, SRC_PCA} alu_src_e;
        typedef enum logic {SIGN_EXT = 1'b0, ZERO_EXT = 1'b1} ext_e;
        typedef enum logic [1:0] {MEM_NOOP, MEM_LOAD, MEM_STOR} mem_type_e;
        typedef enum logic [2:0] {SZ_BYTE, SZ_HALF, SZ_FULL} mem_size_e;

        typedef struct packed {
                inst_t instruction;
                logic  is_branch;
                logic  is_branch_al;
        } fetch_t;

        typedef struct packed {
                logic      undefined_inst;
                logic      priv_inst;
                alu_op_e   alu_op;
                alu_src_e  alu_src;
                ext_e      alu_imm_src;
                mem_type_e mem_type;
                mem_size_e mem_size;
                reg_addr_t wb_reg_dest;
                logic      wb_reg_en;
                ext_e      unsigned_flag; // Load extension in MEM
        } ctrl_t;

        // Harmless word, no side effects in any stage
        localparam ctrl_t CTRL_NEUTRAL = '{
                undefined_inst: 1'b0,
                priv_inst:      1'b0,
                alu_op:         ALU_ADDU,
                alu_src:        SRC_REG,
                alu_imm_src:    SIGN_EXT,
                mem_type:       MEM_NOOP,
                mem_size:       SZ_FULL,
                wb_reg_dest:    5'd0,
                wb_reg_en:      1'b0,
                unsigned_flag:  SIGN_EXT
        };

endpackage

//--- verilog/pipe_stage.sv
module pipe_stage #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     rst_n,

        input  logic     in_req,
        output logic     in_ack,
        input  payload_t in_data,

        output logic     out_req,
        input  logic     out_ack,
        output payload_t out_data
);

        logic     full;
        logic     capture;
        payload_t data_q;

        // Empty, request seen and previous input handshake closed
        assign capture = !full && in_req && !in_ack;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        full    <= 1'b0;
                        in_ack  <= 1'b0;
                        out_req <= 1'b0;
                end else begin
                        if (capture) begin
                                full    <= 1'b1;
                                in_ack  <= 1'b1;
                                out_req <= 1'b1;
                        end

                        if (in_ack && !in_req)
                                in_ack <= 1'b0;

                        if (out_req && out_ack)
                                out_req <= 1'b0; // Consumer took it

                        // Output handshake fully returned to zero
                        if (full && !out_req && !out_ack)
                                full <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (capture)
                        data_q <= in_data;
        end

        assign out_data = data_q;

endmodule

//--- decoder/alu_decode.sv
module alu_decode import decode_pkg::*; (
        input  logic [5:0] opcode,
        input  logic [5:0] funct,
        input  reg_addr_t  rt,
        input  reg_addr_t  rd,
        output logic       hit,
        output ctrl_t      ctrl
);

        always_comb begin
                ctrl               = CTRL_NEUTRAL;
                ctrl.unsigned_flag = ZERO_EXT;
                ctrl.wb_reg_en     = 1'b1;
                hit                = 1'b1;

                if (opcode == OPC_SPECIAL) begin
                        ctrl.wb_reg_dest = rd;
                        case (funct)
                                FN_ADD:   ctrl.alu_op = ALU_ADD;
                                FN_ADDU:  ctrl.alu_op = ALU_ADDU;
                                FN_SUB:   ctrl.alu_op = ALU_SUB;
                                FN_SUBU:  ctrl.alu_op = ALU_SUBU;
                                FN_SLT:   ctrl.alu_op = ALU_SLT;
                                FN_SLTU:  ctrl.alu_op = ALU_SLTU;
                                FN_AND:   ctrl.alu_op = ALU_AND;
                                FN_OR:    ctrl.alu_op = ALU_OR;
                                FN_XOR:   ctrl.alu_op = ALU_XOR;
                                FN_NOR:   ctrl.alu_op = ALU_NOR;
                                FN_SLL:   ctrl.alu_op = ALU_SLL;
                                FN_SRL:   ctrl.alu_op = ALU_SRL;
                                FN_SRA:   ctrl.alu_op = ALU_SRA;
                                FN_SLLV:  ctrl.alu_op = ALU_SLL;
                                FN_SRLV:  ctrl.alu_op = ALU_SRL;
                                FN_SRAV:  ctrl.alu_op = ALU_SRA;
                                FN_MULT:  ctrl.alu_op = ALU_MULT;
                                FN_MULTU: ctrl.alu_op = ALU_MULTU;
                                FN_DIV:   ctrl.alu_op = ALU_DIV;
                                FN_DIVU:  ctrl.alu_op = ALU_DIVU;
                                FN_MFHI:  ctrl.alu_op = ALU_MFHI;
                                FN_MFLO:  ctrl.alu_op = ALU_MFLO;
                                FN_MTHI:  ctrl.alu_op = ALU_MTHI;
                                FN_MTLO:  ctrl.alu_op = ALU_MTLO;
                                default:  hit = 1'b0; // BREAK, SYSCALL and unknown
                        endcase

                        // Shift amount comes from the shamt field
                        if (funct inside {FN_SLL, FN_SRL, FN_SRA})
                                ctrl.alu_src = SRC_SFT;

                        // Results land in HI/LO, not the register file
                        if (funct inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
                                          FN_MTHI, FN_MTLO})
                                ctrl.wb_reg_en = 1'b0;
                end else begin
                        ctrl.alu_src     = SRC_IMM;
                        ctrl.wb_reg_dest = rt;
                        case (opcode)
                                OPC_ADDI:  ctrl.alu_op = ALU_ADD;
                                OPC_ADDIU: ctrl.alu_op = ALU_ADDU;
                                OPC_SLTI:  ctrl.alu_op = ALU_SLT;
                                OPC_SLTIU: ctrl.alu_op = ALU_SLTU;
                                OPC_ANDI:  ctrl.alu_op = ALU_AND;
                                OPC_ORI:   ctrl.alu_op = ALU_OR;
                                OPC_XORI:  ctrl.alu_op = ALU_XOR;
                                OPC_LUI:   ctrl.alu_op = ALU_LUI;
                                default:   hit = 1'b0;
                        endcase

                        // Logical immediates are zero extended
                        if (opcode inside {OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI})
                                ctrl.alu_imm_src = ZERO_EXT;
                end
        end

endmodule

//--- decoder/mem_decode.sv
module mem_decode import decode_pkg::*; (
        input  logic [5:0] opcode,
        input  reg_addr_t  rt,
        output logic       hit,
        output ctrl_t      ctrl
);

        always_comb begin
                ctrl             = CTRL_NEUTRAL; // Address is rs + sign extended offset
                ctrl.alu_src     = SRC_IMM;
                ctrl.wb_reg_dest = rt;
                ctrl.mem_type    = opcode[3] ? MEM_STOR : MEM_LOAD; // 101xxx are stores
                ctrl.wb_reg_en   = !opcode[3];
                hit              = 1'b1;

                case (opcode)
                        OPC_LB, OPC_SB: begin
                                ctrl.mem_size      = SZ_BYTE;
                                ctrl.unsigned_flag = SIGN_EXT;
                        end
                        OPC_LBU: begin
                                ctrl.mem_size      = SZ_BYTE;
                                ctrl.unsigned_flag = ZERO_EXT;
                        end
                        OPC_LH, OPC_SH: begin
                                ctrl.mem_size      = SZ_HALF;
                                ctrl.unsigned_flag = SIGN_EXT;
                        end
                        OPC_LHU: begin
                                ctrl.mem_size      = SZ_HALF;
                                ctrl.unsigned_flag = ZERO_EXT;
                        end
                        OPC_LW, OPC_SW: begin
                                ctrl.mem_size      = SZ_FULL;
                                ctrl.unsigned_flag = ZERO_EXT;
                        end
                        default: begin
                                hit = 1'b0;
                        end
                endcase
        end

endmodule

//--- decoder/priv_decode.sv
module priv_decode import decode_pkg::*; (
        input  inst_t instruction,
        output logic  hit,
        output ctrl_t ctrl
);

        logic [5:0] opcode;
        logic [5:0] funct;
        logic [4:0] rs;
        reg_addr_t  rt;
        logic       tlb_op;

        assign opcode = instruction[31:26];
        assign funct  = instruction[5:0];
        assign rs     = instruction[25:21];
        assign rt     = instruction[20:16];
        assign tlb_op = instruction[25]; // CO bit

        always_comb begin
                ctrl               = CTRL_NEUTRAL;
                ctrl.priv_inst     = 1'b1;
                ctrl.wb_reg_dest   = rt;
                ctrl.unsigned_flag = ZERO_EXT;
                hit                = 1'b1;

                if (opcode == OPC_SPECIAL && funct == FN_BREAK) begin
                        ctrl.alu_op = ALU_BREK;
                end else if (opcode == OPC_SPECIAL && funct == FN_SYSCALL) begin
                        ctrl.alu_op = ALU_SYSC;
                end else if (opcode == OPC_COP0) begin
                        if (instruction == ERET_WORD) begin
                                ctrl.alu_op = ALU_ERET;
                        end else if (rs == COP0_MF) begin
                                ctrl.alu_op    = ALU_MFC0;
                                ctrl.wb_reg_en = 1'b1;
                        end else if (rs == COP0_MT) begin
                                ctrl.alu_op = ALU_MTC0;
                        end else if (tlb_op && funct == FN_TLBP) begin
                                ctrl.alu_op = ALU_TLBP;
                        end else if (tlb_op && funct == FN_TLBR) begin
                                ctrl.alu_op = ALU_TLBR;
                        end else if (tlb_op && funct == FN_TLBWI) begin
                                ctrl.alu_op = ALU_TLBWI;
                        end else if (tlb_op && funct == FN_TLBWR) begin
                                ctrl.alu_op = ALU_TLBWR;
                        end else begin
                                // Still a COP0 word, so it stays privileged
                                ctrl                = CTRL_NEUTRAL;
                                ctrl.priv_inst      = 1'b1;
                                ctrl.undefined_inst = 1'b1;
                        end
                end else begin
                        hit = 1'b0;
                end
        end

endmodule

//--- decoder/decode_core.sv
module decode_core import decode_pkg::*; (
        input  fetch_t fetch,
        output ctrl_t  ctrl
);

        logic [5:0] opcode;
        logic [5:0] funct;
        reg_addr_t  rt;
        reg_addr_t  rd;

        logic       alu_hit;
        logic       mem_hit;
        logic       priv_hit;
        ctrl_t      alu_ctrl;
        ctrl_t      mem_ctrl;
        ctrl_t      priv_ctrl;

        assign opcode = fetch.instruction[31:26];
        assign rt     = fetch.instruction[20:16];
        assign rd     = fetch.instruction[15:11];
        assign funct  = fetch.instruction[5:0];

        alu_decode u_alu (
                .opcode (opcode),
                .funct  (funct),
                .rt     (rt),
                .rd     (rd),
                .hit    (alu_hit),
                .ctrl   (alu_ctrl)
        );

        mem_decode u_mem (
                .opcode (opcode),
                .rt     (rt),
                .hit    (mem_hit),
                .ctrl   (mem_ctrl)
        );

        priv_decode u_priv (
                .instruction (fetch.instruction),
                .hit         (priv_hit),
                .ctrl        (priv_ctrl)
        );

        // Claims are disjoint, so the order here is arbitrary
        always_comb begin
                ctrl = CTRL_NEUTRAL;
                if (alu_hit) begin
                        ctrl = alu_ctrl;
                end else if (mem_hit) begin
                        ctrl = mem_ctrl;
                end else if (priv_hit) begin
                        ctrl = priv_ctrl;
                end else if (fetch.is_branch && fetch.is_branch_al) begin
                        ctrl.alu_op        = ALU_OUTA; // Return address to r31
                        ctrl.alu_src       = SRC_PCA;
                        ctrl.wb_reg_dest   = LINK_REG;
                        ctrl.wb_reg_en     = 1'b1;
                        ctrl.unsigned_flag = ZERO_EXT;
                end else begin
                        ctrl.undefined_inst = !fetch.is_branch; // Plain branches are legal
                end
        end

endmodule

//--- verilog/decode_top.sv
module decode_top import decode_pkg::*; (
        input  logic  clk,
        input  logic  rst_n,

        input  logic  in_req,
        input  inst_t instruction,
        input  logic  is_branch,
        input  logic  is_branch_al,
        output logic  in_ack,

        output logic  out_req,
        input  logic  out_ack,
        output ctrl_t ctrl
);

        fetch_t fetch_in;
        fetch_t fetch_q;
        ctrl_t  ctrl_d;
        logic   mid_req;
        logic   mid_ack;

        assign fetch_in = {instruction, is_branch, is_branch_al};

        pipe_stage #(
                .payload_t (fetch_t)
        ) u_capture (
                .clk      (clk),
                .rst_n    (rst_n),
                .in_req   (in_req),
                .in_ack   (in_ack),
                .in_data  (fetch_in),
                .out_req  (mid_req),
                .out_ack  (mid_ack),
                .out_data (fetch_q)
        );

        decode_core u_core (
                .fetch (fetch_q),
                .ctrl  (ctrl_d)
        );

        pipe_stage #(
                .payload_t (ctrl_t)
        ) u_result (
                .clk      (clk),
                .rst_n    (rst_n),
                .in_req   (mid_req),
                .in_ack   (mid_ack),
                .in_data  (ctrl_d),
                .out_req  (out_req),
                .out_ack  (out_ack),
                .out_data (ctrl)
        );

endmodule

//--- test/decode_checker.sv
module decode_checker import decode_pkg::*; (
        input logic  clk,
        input logic  rst_n,
        input logic  in_req,
        input logic  in_ack,
        input logic  out_req,
        input logic  out_ack,
        input ctrl_t ctrl
);
        timeunit 1ns;
        timeprecision 1ps;

        int unsigned fail_count = 0; // Read by the testbench at the end

        ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
                $rose(in_ack) |-> $past(in_req))
        else begin
                $error("in_ack rose without in_req");
                fail_count++;
        end

        req_held: assert property (@(posedge clk) disable iff (!rst_n)
                out_req && !out_ack |=> out_req)
        else begin
                $error("out_req dropped before out_ack");
                fail_count++;
        end

        ctrl_held: assert property (@(posedge clk) disable iff (!rst_n)
                out_req && !out_ack |=> $stable(ctrl))
        else begin
                $error("ctrl changed while waiting for out_ack");
                fail_count++;
        end

        reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !in_ack && !out_req)
        else begin
                $error("handshake outputs not idle after reset");
                fail_count++;
        end

endmodule

//--- test/tb_decode.sv
module tb_decode import decode_pkg::*; ();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int N_DIRECTED = 54;
        localparam int N_RANDOM   = 200;
        localparam int TIMEOUT    = 40 * (N_DIRECTED + N_RANDOM) + 100;

        localparam logic [5:0] R_FUNCTS [24] = '{
                FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_AND, FN_OR,
                FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO};
        localparam logic [5:0] MEM_OPS [8] = '{
                OPC_LB, OPC_LBU, OPC_LH, OPC_LHU, OPC_LW, OPC_SB, OPC_SH, OPC_SW};

        // Op tables indexed straight from the encoding bits
        localparam alu_op_e ARITH_OPS [8] = '{ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
                                              ALU_AND, ALU_OR, ALU_XOR, ALU_NOR};
        localparam alu_op_e IMM_OPS [8] = '{ALU_ADD, ALU_ADDU, ALU_SLT, ALU_SLTU,
                                            ALU_AND, ALU_OR, ALU_XOR, ALU_LUI};
        localparam alu_op_e SHIFT_OPS [4] = '{ALU_SLL, ALU_SLL, ALU_SRL, ALU_SRA}; // Slot 1 unused
        localparam alu_op_e MULDIV_OPS [4] = '{ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU};
        localparam alu_op_e HILO_OPS [4] = '{ALU_MFHI, ALU_MTHI, ALU_MFLO, ALU_MTLO};
        localparam ctrl_t NEUTRAL = '{1'b0, 1'b0, ALU_ADDU, SRC_REG, SIGN_EXT, MEM_NOOP,
                                      SZ_FULL, 5'd0, 1'b0, SIGN_EXT};

        logic  clk = 1'b0;
        logic  rst_n;
        logic  in_req;
        inst_t instruction;
        logic  is_branch;
        logic  is_branch_al;
        logic  in_ack;
        logic  out_req;
        logic  out_ack;
        ctrl_t ctrl;

        logic [15:0] lfsr = 16'd58;
        fetch_t      exp_q[$];
        string       name_q[$];
        int          n_sent = 0;
        int          n_recv = 0;
        int          n_mismatch = 0;
        int          n_other = 0;
        int          n_assert = 0;
        int          cycles = 0;

        decode_top i_dut (.*);

        bind decode_top decode_checker u_checker (.*);

        always #10 clk = ~clk;

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                int          i;
                v = '0;
                for (i = 0; i < n; i++) begin
                        v    = {v[30:0], lfsr[0]};
                        lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
                end
                return v;
        endfunction

        function automatic ctrl_t ref_decode(input fetch_t f);
                ctrl_t      c;
                logic [5:0] op;
                logic [5:0] fn;
                logic [4:0] rs;
                logic [4:0] rt;
                logic       hit;
                op  = f.instruction[31:26];
                fn  = f.instruction[5:0];
                rs  = f.instruction[25:21];
                rt  = f.instruction[20:16];
                c   = NEUTRAL;
                hit = 1'b1;
                if (op == OPC_SPECIAL && fn inside {FN_BREAK, FN_SYSCALL}) begin
                        c.priv_inst     = 1'b1;
                        c.alu_op        = (fn == FN_BREAK) ? ALU_BREK : ALU_SYSC;
                        c.wb_reg_dest   = rt;
                        c.unsigned_flag = ZERO_EXT;
                end else if (op == OPC_SPECIAL) begin
                        c.wb_reg_dest   = f.instruction[15:11];
                        c.wb_reg_en     = !(fn[5:2] == 4'b0110 || fn inside {FN_MTHI, FN_MTLO});
                        c.unsigned_flag = ZERO_EXT;
                        if (fn[5:3] == 3'b100) begin
                                c.alu_op = ARITH_OPS[fn[2:0]];
                        end else if (fn[5:1] == 5'b10101) begin
                                c.alu_op = fn[0] ? ALU_SLTU : ALU_SLT;
                        end else if (fn[5:3] == 3'b000 && fn[1:0] != 2'b01) begin
                                c.alu_op  = SHIFT_OPS[fn[1:0]];
                                c.alu_src = fn[2] ? SRC_REG : SRC_SFT; // Variable shifts use rs
                        end else if (fn[5:2] == 4'b0110) begin
                                c.alu_op = MULDIV_OPS[fn[1:0]];
                        end else if (fn[5:2] == 4'b0100) begin
                                c.alu_op = HILO_OPS[fn[1:0]];
                        end else begin
                                hit = 1'b0;
                        end
                end else if (op[5:3] == 3'b001) begin
                        c.alu_op        = IMM_OPS[op[2:0]];
                        c.alu_src       = SRC_IMM;
                        c.alu_imm_src   = op[2] ? ZERO_EXT : SIGN_EXT; // Logical group
                        c.wb_reg_dest   = rt;
                        c.wb_reg_en     = 1'b1;
                        c.unsigned_flag = ZERO_EXT;
                end else if (op inside {OPC_LB, OPC_LBU, OPC_LH, OPC_LHU, OPC_LW,
                                        OPC_SB, OPC_SH, OPC_SW}) begin
                        c.alu_src       = SRC_IMM;
                        c.wb_reg_dest   = rt;
                        c.mem_type      = MEM_LOAD;
                        c.wb_reg_en     = 1'b1;
                        if (op inside {OPC_SB, OPC_SH, OPC_SW}) begin
                                c.mem_type  = MEM_STOR;
                                c.wb_reg_en = 1'b0;
                        end
                        c.mem_size      = op[1] ? SZ_FULL : (op[0] ? SZ_HALF : SZ_BYTE);
                        c.unsigned_flag = (op[2] || op[1]) ? ZERO_EXT : SIGN_EXT;
                end else if (op == OPC_COP0) begin
                        c.priv_inst     = 1'b1;
                        c.wb_reg_dest   = rt;
                        c.unsigned_flag = ZERO_EXT;
                        if (f.instruction == ERET_WORD) begin
                                c.alu_op = ALU_ERET;
                        end else if (rs == COP0_MF) begin
                                c.alu_op    = ALU_MFC0;
                                c.wb_reg_en = 1'b1;
                        end else if (rs == COP0_MT) begin
                                c.alu_op = ALU_MTC0;
                        end else if (f.instruction[25] && fn == FN_TLBP) begin
                                c.alu_op = ALU_TLBP;
                        end else if (f.instruction[25] && fn == FN_TLBR) begin
                                c.alu_op = ALU_TLBR;
                        end else if (f.instruction[25] && fn == FN_TLBWI) begin
                                c.alu_op = ALU_TLBWI;
                        end else if (f.instruction[25] && fn == FN_TLBWR) begin
                                c.alu_op = ALU_TLBWR;
                        end else begin
                                c                = NEUTRAL;
                                c.priv_inst      = 1'b1;
                                c.undefined_inst = 1'b1;
                        end
                end else begin
                        hit = 1'b0;
                end
                if (!hit) begin
                        c = NEUTRAL;
                        if (f.is_branch && f.is_branch_al) begin
                                c.alu_op        = ALU_OUTA;
                                c.alu_src       = SRC_PCA;
                                c.wb_reg_dest   = LINK_REG;
                                c.wb_reg_en     = 1'b1;
                                c.unsigned_flag = ZERO_EXT;
                        end else begin
                                c.undefined_inst = !f.is_branch;
                        end
                end
                return c;
        endfunction

        task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
                if (act !== exp) begin
                        n_mismatch++;
                        $display("ERR %s: expected %h actual %h at %0t", name, exp, act, $time);
                end
        endtask

        task automatic send_fetch(input string name, input inst_t w, input logic br,
                                  input logic al);
                exp_q.push_back({w, br, al});
                name_q.push_back(name);
                n_sent++;
                instruction  = w;
                is_branch    = br;
                is_branch_al = al;
                in_req       = 1'b1;
                @(posedge clk);
                #2;
                while (!in_ack) begin
                        @(posedge clk);
                        #2;
                end
                in_req = 1'b0;
                while (in_ack) begin
                        @(posedge clk);
                        #2;
                end
        endtask

        // Output side consumer with random ack delay
        initial begin
                int d;
                out_ack = 1'b0;
                forever begin
                        @(posedge clk);
                        #2;
                        if (out_req) begin
                                d = rand_bits(2);
                                repeat (d) @(posedge clk);
                                if (d != 0)
                                        #2;
                                out_ack = 1'b1;
                                while (out_req) begin
                                        @(posedge clk);
                                        #2;
                                end
                                out_ack = 1'b0;
                        end
                end
        end

        initial begin
                forever begin
                        @(posedge out_req);
                        #1;
                        n_recv++;
                        if (exp_q.size() == 0) begin
                                n_other++;
                                $display("A result arrived with no instruction pending");
                        end else begin
                                check_ctrl(name_q.pop_front(), ref_decode(exp_q.pop_front()),
                                           ctrl);
                        end
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles == TIMEOUT) begin
                        $display("Timeout after %0d cycles, %0d results outstanding",
                                 cycles, exp_q.size());
                        $display("TB FAILED");
                        $finish;
                end
        end

        initial begin
                rst_n        = 1'b0;
                in_req       = 1'b0;
                instruction  = '0;
                is_branch    = 1'b0;
                is_branch_al = 1'b0;
                repeat (2) @(posedge clk);
                #2;
                rst_n = 1'b1;

                foreach (R_FUNCTS[i])
                        send_fetch("rtype", {OPC_SPECIAL, 20'(rand_bits(20)), R_FUNCTS[i]}, 0, 0);
                for (int op = 8; op < 16; op++)
                        send_fetch("itype", {6'(op), 26'(rand_bits(26))}, 0, 0);
                foreach (MEM_OPS[i])
                        send_fetch("mem", {MEM_OPS[i], 26'(rand_bits(26))}, 0, 0);

                send_fetch("break", {OPC_SPECIAL, 20'(rand_bits(20)), FN_BREAK}, 0, 0);
                send_fetch("syscall", {OPC_SPECIAL, 20'(rand_bits(20)), FN_SYSCALL}, 0, 0);
                send_fetch("eret", ERET_WORD, 0, 0);
                send_fetch("mfc0", {OPC_COP0, COP0_MF, 21'(rand_bits(21))}, 0, 0);
                send_fetch("mtc0", {OPC_COP0, COP0_MT, 21'(rand_bits(21))}, 0, 0);
                send_fetch("tlbp", {OPC_COP0, 1'b1, 19'd0, FN_TLBP}, 0, 0);
                send_fetch("tlbr", {OPC_COP0, 1'b1, 19'd0, FN_TLBR}, 0, 0);
                send_fetch("tlbwi", {OPC_COP0, 1'b1, 19'd0, FN_TLBWI}, 0, 0);
                send_fetch("tlbwr", {OPC_COP0, 1'b1, 19'd0, FN_TLBWR}, 0, 0);
                send_fetch("cop0_bad", {OPC_COP0, 5'b00010, 15'd0, 6'b111111}, 0, 0);

                send_fetch("jal_link", {6'b000011, 26'(rand_bits(26))}, 1, 1);
                send_fetch("beq_plain", {6'b000100, 26'(rand_bits(26))}, 1, 0);
                send_fetch("clz", {6'b011100, 20'(rand_bits(20)), 6'b100000}, 0, 0);
                send_fetch("lwl", {6'b100010, 26'(rand_bits(26))}, 0, 0);

                repeat (N_RANDOM)
                        send_fetch("random", rand_bits(32), 1'(rand_bits(1)), 1'(rand_bits(1)));

                while (exp_q.size() != 0)
                        @(posedge clk);
                repeat (10) @(posedge clk); // Catch any duplicate result
                if (n_recv != n_sent) begin
                        n_other++;
                        $display("Sent %0d instructions but received %0d results", n_sent, n_recv);
                end
                n_assert = i_dut.u_checker.fail_count;
                $display("Errors: %0d mismatch, %0d other, %0d assertion",
                         n_mismatch, n_other, n_assert);
                if (n_mismatch + n_other + n_assert == 0)
                        $display("TB PASSED");
                else
                        $display("TB FAILED");
                $finish;
        end

endmodule

//--- sim.f
common/decode_pkg.sv
verilog/pipe_stage.sv
decoder/alu_decode.sv
decoder/mem_decode.sv
decoder/priv_decode.sv
decoder/decode_core.sv
verilog/decode_top.sv
test/decode_checker.sv
test/tb_decode.sv

//--- Bender.yml
package:
  name: mips_decoder

sources:
  - common/decode_pkg.sv
  - verilog/pipe_stage.sv
  - decoder/alu_decode.sv
  - decoder/mem_decode.sv
  - decoder/priv_decode.sv
  - decoder/decode_core.sv
  - verilog/decode_top.sv
  - target: test
    files:
      - test/decode_checker.sv
      - test/tb_decode.sv
